// File: include/rvfi_params.svh
/*
 * Retirement trace port widths and constants
 * Shared by the package, the RTL blocks and the trace checker
 */

`ifndef RVFI_PARAMS_SVH
`define RVFI_PARAMS_SVH

// Program counter width of the traced core
`define RVFI_PC_W 32

// Exception and interrupt code width, the low bits of mcause
`define RVFI_CAUSE_W 6

// Interrupt flag position in mcause, the top bit of an RV32 CSR
`define RVFI_MCAUSE_IRQ_BIT 31

// Width of the count of debug entries that are not yet reported
// Three unreported entries are more than the core can produce between
// two retirements, so the count saturates well before that matters
`define RVFI_ACK_CNT_W 2

`endif

// File: verilog/rvfi_pkg.sv
/*
 * Trace port types
 * Vector types for the fields of a trace record, the dcsr.cause
 * codes and the debug mode state of the trap tracker
 */

`include "rvfi_params.svh"

package rvfi_pkg;

  ////////////////////////////////////////
  // Record fields
  ////////////////////////////////////////

  // Address of a retired instruction
  typedef logic [`RVFI_PC_W-1:0] pc_t;

  // Exception or interrupt code as it lands in mcause
  typedef logic [`RVFI_CAUSE_W-1:0] cause_t;

  // Debug entry cause, same code points as dcsr.cause
  typedef logic [2:0] dbg_cause_t;

  // Full CSR read value
  typedef logic [31:0] csr_word_t;

  // Debug causes used by this port, zero means no debug entry
  localparam dbg_cause_t DBG_CAUSE_EBREAK = 3'd1;
  localparam dbg_cause_t DBG_CAUSE_HALT   = 3'd3;
  localparam dbg_cause_t DBG_CAUSE_STEP   = 3'd4;

  ////////////////////////////////////////
  // Debug mode
  ////////////////////////////////////////

  // Core is running normal code or is halted in debug mode
  typedef enum logic {
    DBG_RUN,
    DBG_HALTED
  } dbg_mode_e;

endpackage

// File: verilog/trap_tracker.sv
/*
 * Trap tracker
 * Collects interrupt, exception and debug entry events into the pending
 * record of the next retirement, runs the debug mode FSM including the
 * forced entry after a single step, and flags the retiring instruction
 */

`include "rvfi_params.svh"

module trap_tracker (
  input  logic                 clk_i,
  input  logic                 rst_ni,
  input  logic                 retire_i,
  input  logic                 exc_i,
  input  rvfi_pkg::cause_t     exc_cause_i,
  input  logic                 irq_ack_i,
  input  logic                 dbg_ack_i,
  input  rvfi_pkg::dbg_cause_t dbg_cause_i,
  input  logic                 dret_i,
  input  logic                 step_i,
  output logic                 pend_intr_o,
  output rvfi_pkg::dbg_cause_t pend_dbg_cause_o,
  output logic                 trap_exc_o,
  output logic                 trap_dbg_o,
  output rvfi_pkg::cause_t     trap_cause_o,
  output rvfi_pkg::dbg_cause_t trap_dbg_cause_o,
  output logic                 dbg_mode_o,
  output logic                 step_entry_o
);

  rvfi_pkg::dbg_mode_e        state_q;
  rvfi_pkg::dbg_mode_e        state_d;
  logic                       step_entry;
  logic                       exc_run;
  logic                       pend_intr_q;
  logic [`RVFI_ACK_CNT_W-1:0] dbg_cnt_q;
  rvfi_pkg::dbg_cause_t       dbg_cause_q;

  // A stepped instruction outside debug mode forces debug entry
  assign step_entry = retire_i && step_i && (state_q == rvfi_pkg::DBG_RUN);
  // Exceptions taken in debug mode do not enter a handler
  assign exc_run    = retire_i && exc_i && (state_q == rvfi_pkg::DBG_RUN);

  ////////////////////////////////////////
  // Debug mode FSM
  ////////////////////////////////////////

  always_comb begin
    state_d = state_q;
    case (state_q)
      rvfi_pkg::DBG_RUN: begin
        // Entry by acknowledge or by the step that just retired
        if (dbg_ack_i || step_entry) begin
          state_d = rvfi_pkg::DBG_HALTED;
        end
      end
      rvfi_pkg::DBG_HALTED: begin
        if (dret_i) begin
          state_d = rvfi_pkg::DBG_RUN;
        end
      end
      default: state_d = rvfi_pkg::DBG_RUN;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= rvfi_pkg::DBG_RUN;
    end else begin
      state_q <= state_d;
    end
  end

  ////////////////////////////////////////
  // Pending record
  ////////////////////////////////////////

  // A retirement consumes the record, and an exception on it opens a new one
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      pend_intr_q <= 1'b0;
      dbg_cnt_q   <= '0;
    end else begin
      if (irq_ack_i || exc_run) begin
        pend_intr_q <= 1'b1;
      end else if (retire_i) begin
        pend_intr_q <= 1'b0;
      end
      // Count of debug entries since the last retirement, saturating
      if (step_entry) begin
        dbg_cnt_q <= `RVFI_ACK_CNT_W'(1);
      end else if (dbg_ack_i) begin
        if (dbg_cnt_q != '1) begin
          dbg_cnt_q <= dbg_cnt_q + 1'b1;
        end
      end else if (retire_i) begin
        dbg_cnt_q <= '0;
      end
    end
  end

  // Latest entry cause, only meaningful while the count is nonzero
  always_ff @(posedge clk_i) begin
    if (step_entry) begin
      dbg_cause_q <= rvfi_pkg::DBG_CAUSE_STEP;
    end else if (dbg_ack_i) begin
      dbg_cause_q <= dbg_cause_i;
    end
  end

  assign pend_intr_o      = pend_intr_q;
  assign pend_dbg_cause_o = (dbg_cnt_q != '0) ? dbg_cause_q : '0;

  // Trap flags of the instruction retiring in this cycle
  assign trap_exc_o       = retire_i && exc_i;
  assign trap_cause_o     = (retire_i && exc_i) ? exc_cause_i : '0;
  assign trap_dbg_o       = step_entry;
  assign trap_dbg_cause_o = step_entry ? rvfi_pkg::DBG_CAUSE_STEP : '0;
  assign step_entry_o     = step_entry;
  assign dbg_mode_o       = (state_q == rvfi_pkg::DBG_HALTED);

endmodule

// File: verilog/csr_shadow.sv
/*
 * CSR shadow
 * Keeps copies of mcause and dcsr as trap and debug entry update them,
 * so each trace record carries the CSR state after its own event
 */

`include "rvfi_params.svh"

module csr_shadow (
  input  logic                 clk_i,
  input  logic                 rst_ni,
  input  logic                 retire_i,
  input  logic                 exc_i,
  input  rvfi_pkg::cause_t     exc_cause_i,
  input  logic                 irq_ack_i,
  input  rvfi_pkg::cause_t     irq_id_i,
  input  logic                 dbg_ack_i,
  input  rvfi_pkg::dbg_cause_t dbg_cause_i,
  input  logic                 step_entry_i,
  input  logic                 dbg_mode_i,
  input  logic                 step_i,
  output rvfi_pkg::csr_word_t  mcause_o,
  output rvfi_pkg::csr_word_t  dcsr_o
);

  rvfi_pkg::csr_word_t  mcause_q;
  rvfi_pkg::csr_word_t  irq_word;
  rvfi_pkg::csr_word_t  exc_word;
  logic                 exc_wr;
  rvfi_pkg::dbg_cause_t dcsr_cause_q;
  logic                 dcsr_step_q;

  ////////////////////////////////////////
  // mcause
  ////////////////////////////////////////

  // Interrupt value has the top flag set and the id in the code field
  always_comb begin
    irq_word = '0;
    irq_word[`RVFI_MCAUSE_IRQ_BIT] = 1'b1;
    irq_word[`RVFI_CAUSE_W-1:0] = irq_id_i;
  end

  // Exception value is the plain code with the flag clear
  assign exc_word = rvfi_pkg::csr_word_t'(exc_cause_i);
  // In debug mode an exception does not trap to a handler
  assign exc_wr   = retire_i && exc_i && !dbg_mode_i;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      mcause_q <= '0;
    end else if (irq_ack_i) begin
      mcause_q <= irq_word;
    end else if (exc_wr) begin
      mcause_q <= exc_word;
    end
  end

  ////////////////////////////////////////
  // dcsr
  ////////////////////////////////////////

  // cause is written on each debug entry, step follows the debugger
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      dcsr_cause_q <= '0;
      dcsr_step_q  <= 1'b0;
    end else begin
      if (step_entry_i) begin
        dcsr_cause_q <= rvfi_pkg::DBG_CAUSE_STEP;
      end else if (dbg_ack_i) begin
        dcsr_cause_q <= dbg_cause_i;
      end
      dcsr_step_q <= step_i;
    end
  end

  assign mcause_o = mcause_q;
  // Bits 8:6 cause, bit 3 nmip (never set here), bit 2 step
  assign dcsr_o   = {23'b0, dcsr_cause_q, 3'b0, dcsr_step_q, 2'b0};

endmodule

// File: verilog/rvfi_retire.sv
/*
 * Retirement record stage
 * Registers each retired instruction with its pending trap annotations
 * and presents one trace record per retirement, one cycle later
 */

module rvfi_retire (
  input  logic                 clk_i,
  input  logic                 rst_ni,
  input  logic                 retire_i,
  input  rvfi_pkg::pc_t        retire_pc_i,
  input  logic                 pend_intr_i,
  input  rvfi_pkg::dbg_cause_t pend_dbg_cause_i,
  input  logic                 trap_exc_i,
  input  logic                 trap_dbg_i,
  input  rvfi_pkg::cause_t     trap_cause_i,
  input  rvfi_pkg::dbg_cause_t trap_dbg_cause_i,
  input  rvfi_pkg::csr_word_t  mcause_i,
  input  rvfi_pkg::csr_word_t  dcsr_i,
  output logic                 rvfi_valid_o,
  output rvfi_pkg::pc_t        rvfi_pc_o,
  output logic                 rvfi_intr_o,
  output logic                 rvfi_trap_exc_o,
  output logic                 rvfi_trap_dbg_o,
  output rvfi_pkg::cause_t     rvfi_trap_cause_o,
  output rvfi_pkg::dbg_cause_t rvfi_trap_dbg_cause_o,
  output rvfi_pkg::dbg_cause_t rvfi_dbg_o,
  output rvfi_pkg::csr_word_t  rvfi_mcause_o,
  output rvfi_pkg::csr_word_t  rvfi_dcsr_o
);

  ////////////////////////////////////////
  // Record register
  ////////////////////////////////////////

  // Strobe lasts one cycle per retirement, with no stall path
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rvfi_valid_o          <= 1'b0;
      rvfi_intr_o           <= 1'b0;
      rvfi_dbg_o            <= '0;
      rvfi_trap_exc_o       <= 1'b0;
      rvfi_trap_dbg_o       <= 1'b0;
      rvfi_trap_cause_o     <= '0;
      rvfi_trap_dbg_cause_o <= '0;
    end else begin
      rvfi_valid_o <= retire_i;
      // Flags hold between records and change only on a retirement
      if (retire_i) begin
        rvfi_intr_o           <= pend_intr_i;
        rvfi_dbg_o            <= pend_dbg_cause_i;
        rvfi_trap_exc_o       <= trap_exc_i;
        rvfi_trap_dbg_o       <= trap_dbg_i;
        rvfi_trap_cause_o     <= trap_cause_i;
        rvfi_trap_dbg_cause_o <= trap_dbg_cause_i;
      end
    end
  end

  // Address of the retired instruction
  always_ff @(posedge clk_i) begin
    if (retire_i) begin
      rvfi_pc_o <= retire_pc_i;
    end
  end

  ////////////////////////////////////////
  // CSR fields
  ////////////////////////////////////////

  // The shadows commit on the same edge as the record, so reading them in
  // the strobe cycle gives the values after this retirement's update
  assign rvfi_mcause_o = mcause_i;
  assign rvfi_dcsr_o   = dcsr_i;

endmodule

// File: verilog/rvfi_top.sv
/*
 * Retirement trace port
 * Turns core retire, trap and debug events into one annotated trace
 * record per retired instruction, with mcause and dcsr shadows
 */

module rvfi_top (
  input  logic                 clk_i,
  input  logic                 rst_ni,
  // Core side
  input  logic                 retire_i,
  input  rvfi_pkg::pc_t        retire_pc_i,
  input  logic                 exc_i,
  input  rvfi_pkg::cause_t     exc_cause_i,
  input  logic                 irq_ack_i,
  input  rvfi_pkg::cause_t     irq_id_i,
  input  logic                 dbg_ack_i,
  input  rvfi_pkg::dbg_cause_t dbg_cause_i,
  input  logic                 dret_i,
  input  logic                 step_i,
  // Trace side
  output logic                 rvfi_valid_o,
  output rvfi_pkg::pc_t        rvfi_pc_o,
  output logic                 rvfi_intr_o,
  output logic                 rvfi_trap_exc_o,
  output logic                 rvfi_trap_dbg_o,
  output rvfi_pkg::cause_t     rvfi_trap_cause_o,
  output rvfi_pkg::dbg_cause_t rvfi_trap_dbg_cause_o,
  output rvfi_pkg::dbg_cause_t rvfi_dbg_o,
  output rvfi_pkg::csr_word_t  rvfi_mcause_o,
  output rvfi_pkg::csr_word_t  rvfi_dcsr_o
);

  // Pending record and trap flags from the tracker
  logic                 pend_intr;
  rvfi_pkg::dbg_cause_t pend_dbg_cause;
  logic                 trap_exc;
  logic                 trap_dbg;
  rvfi_pkg::cause_t     trap_cause;
  rvfi_pkg::dbg_cause_t trap_dbg_cause;
  logic                 dbg_mode;
  logic                 step_entry;
  // Shadow CSR values
  rvfi_pkg::csr_word_t  mcause;
  rvfi_pkg::csr_word_t  dcsr;

  trap_tracker u_trap_tracker (
    .clk_i, .rst_ni, .retire_i, .exc_i, .exc_cause_i, .irq_ack_i,
    .dbg_ack_i, .dbg_cause_i, .dret_i, .step_i,
    .pend_intr_o      (pend_intr),
    .pend_dbg_cause_o (pend_dbg_cause),
    .trap_exc_o       (trap_exc),
    .trap_dbg_o       (trap_dbg),
    .trap_cause_o     (trap_cause),
    .trap_dbg_cause_o (trap_dbg_cause),
    .dbg_mode_o       (dbg_mode),
    .step_entry_o     (step_entry)
  );

  csr_shadow u_csr_shadow (
    .clk_i, .rst_ni, .retire_i, .exc_i, .exc_cause_i, .irq_ack_i,
    .irq_id_i, .dbg_ack_i, .dbg_cause_i, .step_i,
    .step_entry_i (step_entry),
    .dbg_mode_i   (dbg_mode),
    .mcause_o     (mcause),
    .dcsr_o       (dcsr)
  );

  rvfi_retire u_rvfi_retire (
    .clk_i, .rst_ni, .retire_i, .retire_pc_i,
    .pend_intr_i      (pend_intr),
    .pend_dbg_cause_i (pend_dbg_cause),
    .trap_exc_i       (trap_exc),
    .trap_dbg_i       (trap_dbg),
    .trap_cause_i     (trap_cause),
    .trap_dbg_cause_i (trap_dbg_cause),
    .mcause_i         (mcause),
    .dcsr_i           (dcsr),
    .rvfi_valid_o, .rvfi_pc_o, .rvfi_intr_o, .rvfi_trap_exc_o,
    .rvfi_trap_dbg_o, .rvfi_trap_cause_o, .rvfi_trap_dbg_cause_o,
    .rvfi_dbg_o, .rvfi_mcause_o, .rvfi_dcsr_o
  );

endmodule

// File: test/rvfi_chk.sv
/*
 * Trace port checker
 * Concurrent assertions on the records of rvfi_top, with a small model
 * of the pending interrupt, debug entry and single step events
 */

`include "rvfi_params.svh"

module rvfi_chk (
  input logic                 clk_i,
  input logic                 rst_ni,
  input logic                 retire_i,
  input rvfi_pkg::pc_t        retire_pc_i,
  input logic                 exc_i,
  input logic                 irq_ack_i,
  input rvfi_pkg::cause_t     irq_id_i,
  input logic                 dbg_ack_i,
  input rvfi_pkg::dbg_cause_t dbg_cause_i,
  input logic                 dret_i,
  input logic                 step_i,
  input logic                 pend_intr_i,
  input logic                 rvfi_valid_o,
  input rvfi_pkg::pc_t        rvfi_pc_o,
  input logic                 rvfi_intr_o,
  input logic                 rvfi_trap_exc_o,
  input logic                 rvfi_trap_dbg_o,
  input rvfi_pkg::cause_t     rvfi_trap_cause_o,
  input rvfi_pkg::dbg_cause_t rvfi_trap_dbg_cause_o,
  input rvfi_pkg::dbg_cause_t rvfi_dbg_o,
  input rvfi_pkg::csr_word_t  rvfi_mcause_o,
  input rvfi_pkg::csr_word_t  rvfi_dcsr_o
);

  int                         fail_cnt = 0;
  // Model state, one bit each unless noted
  logic                       mode_q;
  logic                       irq_pend_q;
  rvfi_pkg::cause_t           irq_id_q;
  logic                       exc_open_q;
  logic                       dexc_q;
  logic                       stepx_q;
  logic [`RVFI_ACK_CNT_W-1:0] dbg_cnt_q;
  rvfi_pkg::dbg_cause_t       dbg_cause_q;
  logic                       step_entry;

  function automatic void report_violation(input string msg);
    $error("Fail %0t: %s", $time, msg);
    fail_cnt++;
  endfunction

  // A step outside debug mode halts the core without an acknowledge
  assign step_entry = retire_i && step_i && !mode_q;

  ////////////////////////////////////////
  // Event model
  ////////////////////////////////////////

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      mode_q      <= 1'b0;
      irq_pend_q  <= 1'b0;
      irq_id_q    <= '0;
      exc_open_q  <= 1'b0;
      dexc_q      <= 1'b0;
      stepx_q     <= 1'b0;
      dbg_cnt_q   <= '0;
      dbg_cause_q <= '0;
    end else begin
      if (dbg_ack_i || step_entry) begin
        mode_q <= 1'b1;
      end else if (dret_i) begin
        mode_q <= 1'b0;
      end
      if (irq_ack_i) begin
        irq_pend_q <= 1'b1;
        irq_id_q   <= irq_id_i;
      end else if (retire_i) begin
        irq_pend_q <= 1'b0;
      end
      // Each of these describes the last retirement only
      if (retire_i) begin
        exc_open_q <= exc_i && !mode_q;
        dexc_q     <= exc_i && mode_q;
        stepx_q    <= step_entry && exc_i;
      end
      if (irq_ack_i) begin
        dexc_q <= 1'b0;
      end
      if (dbg_ack_i) begin
        stepx_q <= 1'b0;
      end
      // Debug entries waiting for a record to report them
      if (step_entry) begin
        dbg_cnt_q   <= `RVFI_ACK_CNT_W'(1);
        dbg_cause_q <= rvfi_pkg::DBG_CAUSE_STEP;
      end else if (dbg_ack_i) begin
        dbg_cause_q <= dbg_cause_i;
        if (dbg_cnt_q != '1) begin
          dbg_cnt_q <= dbg_cnt_q + 1'b1;
        end
      end else if (retire_i) begin
        dbg_cnt_q <= '0;
      end
    end
  end

  ////////////////////////////////////////
  // Record latency
  ////////////////////////////////////////

  a_record_pc: assert property (@(posedge clk_i) disable iff (!rst_ni)
    retire_i |=> rvfi_valid_o && rvfi_pc_o == $past(retire_pc_i) &&
      rvfi_trap_exc_o == $past(exc_i))
    else report_violation("no record after a retirement, or wrong pc or exception flag");

  a_no_spurious: assert property (@(posedge clk_i) disable iff (!rst_ni)
    rvfi_valid_o |-> $past(retire_i))
    else report_violation("a record appeared without a retirement before it");

  a_step_bit: assert property (@(posedge clk_i) disable iff (!rst_ni)
    rvfi_valid_o |-> rvfi_dcsr_o[2] == $past(step_i))
    else report_violation("dcsr.step does not follow the step request");

  ////////////////////////////////////////
  // Interrupts and exceptions
  ////////////////////////////////////////

  a_irq_pend: assert property (@(posedge clk_i) disable iff (!rst_ni)
    irq_ack_i |=> pend_intr_i)
    else report_violation("interrupt acknowledge was not captured as pending");

  // The handler's first record shows the interrupt in mcause
  a_irq_record: assert property (@(posedge clk_i) disable iff (!rst_ni)
    rvfi_valid_o && $past(irq_pend_q) && !rvfi_trap_exc_o |->
      rvfi_intr_o && rvfi_mcause_o[`RVFI_MCAUSE_IRQ_BIT] &&
      rvfi_mcause_o[`RVFI_CAUSE_W-1:0] == $past(irq_id_q))
    else report_violation("record after an interrupt lacks intr or the interrupt mcause");

  a_exc_cause: assert property (@(posedge clk_i) disable iff (!rst_ni)
    rvfi_valid_o && rvfi_trap_exc_o && !$past(mode_q) |->
      !rvfi_mcause_o[`RVFI_MCAUSE_IRQ_BIT] &&
      rvfi_mcause_o[`RVFI_CAUSE_W-1:0] == rvfi_trap_cause_o)
    else report_violation("mcause does not hold the exception code of the trap record");

  a_exc_intr: assert property (@(posedge clk_i) disable iff (!rst_ni)
    rvfi_valid_o && $past(exc_open_q) |-> rvfi_intr_o)
    else report_violation("record after an exception is not marked as a handler entry");

  ////////////////////////////////////////
  // Debug entry and single step
  ////////////////////////////////////////

  a_dbg_source: assert property (@(posedge clk_i) disable iff (!rst_ni)
    rvfi_valid_o && rvfi_dbg_o != '0 |-> $past(dbg_cnt_q) != '0)
    else report_violation("debug cause reported without a debug entry before it");

  a_dbg_cause: assert property (@(posedge clk_i) disable iff (!rst_ni)
    rvfi_valid_o && $past(dbg_cnt_q) != '0 |->
      rvfi_dbg_o == $past(dbg_cause_q) &&
      (rvfi_trap_dbg_o || rvfi_dcsr_o[8:6] == rvfi_dbg_o))
    else report_violation("debug cause or dcsr.cause differs from the debug entry");

  // Only a stepped retirement outside debug mode carries the debug trap, always as STEP
  a_step_cause: assert property (@(posedge clk_i) disable iff (!rst_ni)
    rvfi_valid_o |-> rvfi_trap_dbg_o == $past(step_entry) &&
      rvfi_trap_dbg_cause_o == (rvfi_trap_dbg_o ? rvfi_pkg::DBG_CAUSE_STEP : 3'd0))
    else report_violation("debug trap flag or cause does not match a stepped retirement");

  a_step_next: assert property (@(posedge clk_i) disable iff (!rst_ni)
    rvfi_valid_o && $past(stepx_q) |->
      rvfi_dbg_o == rvfi_pkg::DBG_CAUSE_STEP && rvfi_intr_o &&
      rvfi_dcsr_o[8:6] == rvfi_pkg::DBG_CAUSE_STEP)
    else report_violation("record after a stepped exception lacks step cause or intr");

  // Exceptions in debug mode neither write mcause nor enter a handler
  a_dbg_exc_csr: assert property (@(posedge clk_i) disable iff (!rst_ni)
    rvfi_valid_o && rvfi_trap_exc_o && $past(mode_q) |-> rvfi_mcause_o == $past(rvfi_mcause_o))
    else report_violation("an exception in debug mode changed mcause");

  a_dbg_exc_intr: assert property (@(posedge clk_i) disable iff (!rst_ni)
    rvfi_valid_o && $past(dexc_q) |-> !rvfi_intr_o)
    else report_violation("an exception in debug mode marked the next record as intr");

endmodule

bind rvfi_top rvfi_chk u_chk (.*, .pend_intr_i(pend_intr));

// File: test/rvfi_tb.sv
/*
 * Trace port testbench
 * Plays the core with seeded random retirements, traps and debug events
 * and reports the failures of the bound checker per test
 */

module rvfi_tb;

  localparam int N_RET  = 200;
  localparam int N_IRQ  = 60;
  localparam int N_EXC  = 60;
  localparam int N_DBG  = 30;
  localparam int N_STEP = 30;
  // Worst case cycles per loop, plus reset and two drain cycles per test
  localparam int MAX_CYCLES =
    (26 + 3 * N_RET + 5 * N_IRQ + 4 * N_EXC + 6 * N_DBG + 4 * N_STEP) * 3 / 2;

  // Core event of one cycle
  localparam int IDLE = 0;
  localparam int RET  = 1;
  localparam int IRQ  = 2;
  localparam int DBG  = 3;
  localparam int DRET = 4;

  logic                 clk_i;
  logic                 rst_ni;
  logic                 retire_i;
  rvfi_pkg::pc_t        retire_pc_i;
  logic                 exc_i;
  rvfi_pkg::cause_t     exc_cause_i;
  logic                 irq_ack_i;
  rvfi_pkg::cause_t     irq_id_i;
  logic                 dbg_ack_i;
  rvfi_pkg::dbg_cause_t dbg_cause_i;
  logic                 dret_i;
  logic                 step_i;
  logic                 rvfi_valid_o;
  rvfi_pkg::pc_t        rvfi_pc_o;
  logic                 rvfi_intr_o;
  logic                 rvfi_trap_exc_o;
  logic                 rvfi_trap_dbg_o;
  rvfi_pkg::cause_t     rvfi_trap_cause_o;
  rvfi_pkg::dbg_cause_t rvfi_trap_dbg_cause_o;
  rvfi_pkg::dbg_cause_t rvfi_dbg_o;
  rvfi_pkg::csr_word_t  rvfi_mcause_o;
  rvfi_pkg::csr_word_t  rvfi_dcsr_o;

  logic [31:0]          rng = 32'd94329;
  int                   cycles = 0;
  int                   tests_ok = 0;
  int                   tests_bad = 0;
  int                   fails_at_start = 0;

  rvfi_top dut_i (.*);

  initial clk_i = 1'b0;
  always #10 clk_i = ~clk_i;

  // Cycle limit so a stuck run still ends with a verdict
  always @(posedge clk_i) begin
    cycles <= cycles + 1;
    if (cycles >= MAX_CYCLES) begin
      $display("Timeout: the run did not end within %0d cycles", MAX_CYCLES);
      $display("=== FAIL ===");
      $finish;
    end
  end

  function automatic logic [31:0] xorshift_next();
    rng = rng ^ (rng << 13);
    rng = rng ^ (rng >> 17);
    rng = rng ^ (rng << 5);
    return rng;
  endfunction

  function automatic logic coin();
    logic [31:0] r;
    r = xorshift_next();
    return r[7];
  endfunction

  // Drive one core cycle on the falling edge, data fields always random
  task automatic core_cycle(input int kind, input logic exc);
    logic [31:0] r0;
    logic [31:0] r1;
    @(negedge clk_i);
    r0 = xorshift_next();
    r1 = xorshift_next();
    retire_i    = (kind == RET);
    irq_ack_i   = (kind == IRQ);
    dbg_ack_i   = (kind == DBG);
    dret_i      = (kind == DRET);
    exc_i       = exc;
    retire_pc_i = {r0[31:2], 2'b00};
    exc_cause_i = r1[5:0];
    irq_id_i    = r1[13:8];
    dbg_cause_i = r1[16] ? rvfi_pkg::DBG_CAUSE_EBREAK : rvfi_pkg::DBG_CAUSE_HALT;
  endtask

  task automatic random_gap();
    logic [31:0] r;
    r = xorshift_next();
    repeat (r % 3) core_cycle(IDLE, 1'b0);
  endtask

  // Let the last record leave the port, then count this test's failures
  task automatic finish_test(input string name);
    int delta;
    core_cycle(IDLE, 1'b0);
    core_cycle(IDLE, 1'b0);
    delta = dut_i.u_chk.fail_cnt - fails_at_start;
    fails_at_start = dut_i.u_chk.fail_cnt;
    if (delta == 0) begin
      tests_ok++;
    end else begin
      tests_bad++;
    end
    $display("Test %s done, %0d assertion failures", name, delta);
  endtask

  initial begin
    rst_ni      = 1'b0;
    retire_i    = 1'b0;
    retire_pc_i = '0;
    exc_i       = 1'b0;
    exc_cause_i = '0;
    irq_ack_i   = 1'b0;
    irq_id_i    = '0;
    dbg_ack_i   = 1'b0;
    dbg_cause_i = '0;
    dret_i      = 1'b0;
    step_i      = 1'b0;
    repeat (16) @(negedge clk_i);
    rst_ni = 1'b1;

    repeat (N_RET) begin
      core_cycle(RET, 1'b0);
      random_gap();
    end
    finish_test("retire");

    // Handler entry after an interrupt, later exceptions stay pending
    repeat (N_IRQ) begin
      core_cycle(IRQ, 1'b0);
      random_gap();
      core_cycle(RET, 1'b0);
      core_cycle(RET, coin());
    end
    finish_test("interrupt");

    repeat (N_EXC) begin
      core_cycle(RET, 1'b1);
      random_gap();
      core_cycle(RET, 1'b0);
    end
    finish_test("exception");

    // Acknowledged debug entry with exceptions inside debug mode
    repeat (N_DBG) begin
      core_cycle(DBG, 1'b0);
      repeat (3) core_cycle(RET, coin());
      core_cycle(DRET, 1'b0);
      core_cycle(RET, 1'b0);
    end
    finish_test("debug");

    // Each stepped retirement halts, one debug retirement, then resume
    step_i = 1'b1;
    repeat (N_STEP) begin
      core_cycle(RET, coin());
      core_cycle(RET, coin());
      core_cycle(DRET, 1'b0);
      core_cycle(IDLE, 1'b0);
    end
    step_i = 1'b0;
    finish_test("step");

    $display("Tests passed: %0d, tests failed: %0d", tests_ok, tests_bad);
    if (tests_bad == 0) begin
      $display("=== PASS ===");
    end else begin
      $display("=== FAIL ===");
    end
    $finish;
  end

endmodule

// File: verilog.f
+incdir+include
verilog/rvfi_pkg.sv
verilog/trap_tracker.sv
verilog/csr_shadow.sv
verilog/rvfi_retire.sv
verilog/rvfi_top.sv
test/rvfi_chk.sv
test/rvfi_tb.sv
